//--- issue_defines.svh
// Issue slice sizing macros

`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

//////////////////////////////////////////////////
// Reservation station geometry
//////////////////////////////////////////////////

`define RS_SIZE   4     // Entries in the station
`define RS_IDX_W  2     // Bits to index one entry

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// One unique tag per in-flight instruction
`define TAG_W     6

// Operands, results and NPC
`define XLEN      32

`endif

//--- issue_pkg.sv
// Issue slice types

`include "issue_defines.svh"

package issue_pkg;

    //////////////////////////////////////////////////
    // ALU opcodes
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,     // a + b
        ALU_SUB = 3'd1,     // a - b
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,     // Shift amount from b[4:0]
        ALU_SRL = 3'd6,     // Logical, zero fill
        ALU_SLT = 3'd7      // Signed compare, result 0 or 1
    } alu_func_e;

    //////////////////////////////////////////////////
    // Packets
    //////////////////////////////////////////////////

    // Issue stage to ALU
    typedef struct packed {
        logic [`XLEN-1:0]     opa;
        logic [`XLEN-1:0]     opb;
        logic [`TAG_W-1:0]    rob_tag;    // Tag of this instruction
        alu_func_e            alu_func;
        logic [`XLEN-1:0]     npc;
        logic [`RS_IDX_W-1:0] rs_tag;     // Station entry it came from
    } is_ex_packet_t;

    // Finished result
    // Also the common data bus payload once delivered
    typedef struct packed {
        logic [`TAG_W-1:0]    rob_tag;
        logic [`XLEN-1:0]     value;
        logic [`XLEN-1:0]     npc;
    } cdb_packet_t;

endpackage

//--- rs_if.sv
// Reservation station to issue stage bus

`timescale 1ns/1ns
`include "issue_defines.svh"

interface rs_if;

    // Per-entry view presented by the station
    logic [`RS_SIZE-1:0]  entry_ready;                // Valid and both operands present
    logic [`XLEN-1:0]     entry_opa      [`RS_SIZE];
    logic [`XLEN-1:0]     entry_opb      [`RS_SIZE];
    logic [`TAG_W-1:0]    entry_rob_tag  [`RS_SIZE];
    issue_pkg::alu_func_e entry_alu_func [`RS_SIZE];
    logic [`XLEN-1:0]     entry_npc      [`RS_SIZE];

    // One-hot, from the issue stage
    logic [`RS_SIZE-1:0]  issue_grant;

    // Station side
    modport station (
        output entry_ready,
        output entry_opa,
        output entry_opb,
        output entry_rob_tag,
        output entry_alu_func,
        output entry_npc,
        input  issue_grant
    );

    // Issue stage side
    modport issue (
        input  entry_ready,
        input  entry_opa,
        input  entry_opb,
        input  entry_rob_tag,
        input  entry_alu_func,
        input  entry_npc,
        output issue_grant
    );

endinterface

//--- reservation_station.sv
// ALU reservation station

`timescale 1ns/1ns
`include "issue_defines.svh"

module reservation_station (
    input  logic                   clock,
    input  logic                   arst_n,
    // Dispatch
    input  logic                   disp_valid,
    output logic                   disp_ready,
    input  logic [`TAG_W-1:0]      disp_rob_tag,
    input  issue_pkg::alu_func_e   disp_alu_func,
    input  logic                   disp_opa_valid,
    input  logic [`XLEN-1:0]       disp_opa,
    input  logic [`TAG_W-1:0]      disp_opa_tag,
    input  logic                   disp_opb_valid,
    input  logic [`XLEN-1:0]       disp_opb,
    input  logic [`TAG_W-1:0]      disp_opb_tag,
    input  logic [`XLEN-1:0]       disp_npc,
    // Result broadcast
    input  logic                   cdb_valid,
    input  issue_pkg::cdb_packet_t cdb_packet,
    rs_if.station                  rs
);

    // Entry control
    logic [`RS_SIZE-1:0]  entry_valid;
    logic [`RS_SIZE-1:0]  opa_valid;
    logic [`RS_SIZE-1:0]  opb_valid;
    // Entry payload
    logic [`TAG_W-1:0]    opa_tag  [`RS_SIZE];    // Producer tags while waiting
    logic [`TAG_W-1:0]    opb_tag  [`RS_SIZE];
    logic [`XLEN-1:0]     opa_val  [`RS_SIZE];
    logic [`XLEN-1:0]     opb_val  [`RS_SIZE];
    logic [`TAG_W-1:0]    rob_tag  [`RS_SIZE];
    issue_pkg::alu_func_e alu_func [`RS_SIZE];
    logic [`XLEN-1:0]     npc      [`RS_SIZE];

    logic [`RS_SIZE-1:0]  alloc_sel;      // One-hot lowest free slot
    logic                 alloc_found;
    logic                 disp_fire;
    logic                 disp_opa_hit;   // Broadcast lands with the dispatch
    logic                 disp_opb_hit;
    logic [`RS_SIZE-1:0]  wake_a;
    logic [`RS_SIZE-1:0]  wake_b;

    //////////////////////////////////////////////////
    // Allocation and tag match
    //////////////////////////////////////////////////

    always_comb begin
        alloc_found = 1'b0;
        alloc_sel   = '0;
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (!alloc_found && !entry_valid[i]) begin
                alloc_sel[i] = 1'b1;
                alloc_found  = 1'b1;
            end
        end
    end

    assign disp_ready   = alloc_found;             // Any free entry
    assign disp_fire    = disp_valid && disp_ready;
    assign disp_opa_hit = !disp_opa_valid && cdb_valid && (cdb_packet.rob_tag == disp_opa_tag);
    assign disp_opb_hit = !disp_opb_valid && cdb_valid && (cdb_packet.rob_tag == disp_opb_tag);

    // Waiting operands snoop the broadcast
    always_comb begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            wake_a[i] = entry_valid[i] && !opa_valid[i] && cdb_valid &&
                        (cdb_packet.rob_tag == opa_tag[i]);
            wake_b[i] = entry_valid[i] && !opb_valid[i] && cdb_valid &&
                        (cdb_packet.rob_tag == opb_tag[i]);
        end
    end

    //////////////////////////////////////////////////
    // Entry state
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            entry_valid <= '0;
            opa_valid   <= '0;
            opb_valid   <= '0;
        end else begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                if (disp_fire && alloc_sel[i]) begin
                    entry_valid[i] <= 1'b1;
                    opa_valid[i]   <= disp_opa_valid || disp_opa_hit;
                    opb_valid[i]   <= disp_opb_valid || disp_opb_hit;
                end else begin
                    if (rs.issue_grant[i])
                        entry_valid[i] <= 1'b0;    // Leaves on issue
                    if (wake_a[i])
                        opa_valid[i] <= 1'b1;
                    if (wake_b[i])
                        opb_valid[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (disp_fire && alloc_sel[i]) begin
                opa_val[i]  <= disp_opa_hit ? cdb_packet.value : disp_opa;
                opb_val[i]  <= disp_opb_hit ? cdb_packet.value : disp_opb;
                opa_tag[i]  <= disp_opa_tag;
                opb_tag[i]  <= disp_opb_tag;
                rob_tag[i]  <= disp_rob_tag;
                alu_func[i] <= disp_alu_func;
                npc[i]      <= disp_npc;
            end else begin
                if (wake_a[i])
                    opa_val[i] <= cdb_packet.value;
                if (wake_b[i])
                    opb_val[i] <= cdb_packet.value;
            end
        end
    end

    // View for the issue stage
    assign rs.entry_ready    = entry_valid & opa_valid & opb_valid;
    assign rs.entry_opa      = opa_val;
    assign rs.entry_opb      = opb_val;
    assign rs.entry_rob_tag  = rob_tag;
    assign rs.entry_alu_func = alu_func;
    assign rs.entry_npc      = npc;

endmodule

//--- stage_is.sv
// Issue select stage

`timescale 1ns/1ns
`include "issue_defines.svh"

module stage_is (
    input  logic                     fu_ready,    // ALU can take a packet
    output logic                     is_valid,
    output issue_pkg::is_ex_packet_t is_packet,
    rs_if.issue                      rs
);

    logic issued;   // First ready entry already taken

    //////////////////////////////////////////////////
    // Fixed priority select, entry 0 first
    //////////////////////////////////////////////////

    always_comb begin
        issued         = 1'b0;
        is_valid       = 1'b0;
        is_packet      = '0;
        rs.issue_grant = '0;

        // Nothing leaves while the ALU is stalled
        if (fu_ready) begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                if (!issued && rs.entry_ready[i]) begin
                    is_valid           = 1'b1;
                    is_packet.opa      = rs.entry_opa[i];
                    is_packet.opb      = rs.entry_opb[i];
                    is_packet.rob_tag  = rs.entry_rob_tag[i];
                    is_packet.alu_func = rs.entry_alu_func[i];
                    is_packet.npc      = rs.entry_npc[i];
                    is_packet.rs_tag   = `RS_IDX_W'(i);    // Entry index

                    rs.issue_grant[i]  = 1'b1;             // Frees the entry at the edge
                    issued             = 1'b1;
                end
            end
        end
    end

endmodule

//--- alu_unit.sv
// Single stage pipelined ALU

`timescale 1ns/1ns
`include "issue_defines.svh"

module alu_unit (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     is_valid,
    input  issue_pkg::is_ex_packet_t is_packet,
    input  logic                     wb_ready,     // Writeback takes ex_packet
    output logic                     fu_ready,
    output logic                     ex_valid,
    output issue_pkg::cdb_packet_t   ex_packet
);

    logic [`XLEN-1:0] alu_result;
    logic             ex_load;      // Stage advances

    //////////////////////////////////////////////////
    // Result compute
    //////////////////////////////////////////////////

    always_comb begin
        case (is_packet.alu_func)
            issue_pkg::ALU_ADD: alu_result = is_packet.opa + is_packet.opb;
            issue_pkg::ALU_SUB: alu_result = is_packet.opa - is_packet.opb;
            issue_pkg::ALU_AND: alu_result = is_packet.opa & is_packet.opb;
            issue_pkg::ALU_OR:  alu_result = is_packet.opa | is_packet.opb;
            issue_pkg::ALU_XOR: alu_result = is_packet.opa ^ is_packet.opb;
            issue_pkg::ALU_SLL: alu_result = is_packet.opa << is_packet.opb[4:0];
            issue_pkg::ALU_SRL: alu_result = is_packet.opa >> is_packet.opb[4:0];
            issue_pkg::ALU_SLT: alu_result = {{(`XLEN-1){1'b0}},
                                  $signed(is_packet.opa) < $signed(is_packet.opb)};
            default:            alu_result = '0;
        endcase
    end

    // Empty, or the held result moves on this cycle
    assign fu_ready = !ex_valid || wb_ready;
    assign ex_load  = fu_ready && is_valid;

    //////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            ex_valid <= 1'b0;
        else if (fu_ready)
            ex_valid <= is_valid;   // Clears when drained with no new issue
    end

    always_ff @(posedge clock) begin
        if (ex_load) begin
            ex_packet.rob_tag <= is_packet.rob_tag;
            ex_packet.value   <= alu_result;
            ex_packet.npc     <= is_packet.npc;
        end
    end

endmodule

//--- result_writeback.sv
// Result output register and broadcast

`timescale 1ns/1ns
`include "issue_defines.svh"

module result_writeback (
    input  logic                   clock,
    input  logic                   arst_n,
    // From the ALU
    input  logic                   ex_valid,
    input  issue_pkg::cdb_packet_t ex_packet,
    output logic                   wb_ready,
    // Result port
    output logic                   res_valid,
    input  logic                   res_ready,
    output logic [`TAG_W-1:0]      res_rob_tag,
    output logic [`XLEN-1:0]       res_value,
    output logic [`XLEN-1:0]       res_npc,
    // Wakeup broadcast
    output logic                   cdb_valid,
    output issue_pkg::cdb_packet_t cdb_packet
);

    issue_pkg::cdb_packet_t res_q;  // Held result

    //////////////////////////////////////////////////
    // One-entry output register
    //////////////////////////////////////////////////

    // Room when empty or the current result leaves now
    assign wb_ready = !res_valid || res_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            res_valid <= 1'b0;
        else if (wb_ready)
            res_valid <= ex_valid;
    end

    // Holds steady while res_ready is low
    always_ff @(posedge clock) begin
        if (wb_ready && ex_valid)
            res_q <= ex_packet;
    end

    assign res_rob_tag = res_q.rob_tag;
    assign res_value   = res_q.value;
    assign res_npc     = res_q.npc;

    //////////////////////////////////////////////////
    // Broadcast
    //////////////////////////////////////////////////

    // Only a delivered value wakes dependents
    assign cdb_valid  = res_valid && res_ready;
    assign cdb_packet = res_q;

endmodule

//--- issue_core_top.sv
// Issue slice top level

`timescale 1ns/1ns
`include "issue_defines.svh"

module issue_core_top (
    input  logic                 clock,
    input  logic                 arst_n,
    // Dispatch
    input  logic                 disp_valid,
    output logic                 disp_ready,
    input  logic [`TAG_W-1:0]    disp_rob_tag,
    input  issue_pkg::alu_func_e disp_alu_func,
    input  logic                 disp_opa_valid,
    input  logic [`XLEN-1:0]     disp_opa,
    input  logic [`TAG_W-1:0]    disp_opa_tag,
    input  logic                 disp_opb_valid,
    input  logic [`XLEN-1:0]     disp_opb,
    input  logic [`TAG_W-1:0]    disp_opb_tag,
    input  logic [`XLEN-1:0]     disp_npc,
    // Result
    output logic                 res_valid,
    input  logic                 res_ready,
    output logic [`TAG_W-1:0]    res_rob_tag,
    output logic [`XLEN-1:0]     res_value,
    output logic [`XLEN-1:0]     res_npc
);

    logic                     is_valid;
    issue_pkg::is_ex_packet_t is_packet;
    logic                     fu_ready;
    logic                     ex_valid;
    issue_pkg::cdb_packet_t   ex_packet;
    logic                     wb_ready;
    logic                     cdb_valid;     // Result delivered this cycle
    issue_pkg::cdb_packet_t   cdb_packet;

    rs_if rs_bus ();

    reservation_station rs_i (
        .clock          (clock),
        .arst_n         (arst_n),
        .disp_valid     (disp_valid),
        .disp_ready     (disp_ready),
        .disp_rob_tag   (disp_rob_tag),
        .disp_alu_func  (disp_alu_func),
        .disp_opa_valid (disp_opa_valid),
        .disp_opa       (disp_opa),
        .disp_opa_tag   (disp_opa_tag),
        .disp_opb_valid (disp_opb_valid),
        .disp_opb       (disp_opb),
        .disp_opb_tag   (disp_opb_tag),
        .disp_npc       (disp_npc),
        .cdb_valid      (cdb_valid),
        .cdb_packet     (cdb_packet),
        .rs             (rs_bus.station)
    );

    // Combinational pick, same cycle as the entries
    stage_is is_i (
        .fu_ready  (fu_ready),
        .is_valid  (is_valid),
        .is_packet (is_packet),
        .rs        (rs_bus.issue)
    );

    alu_unit alu_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .is_valid  (is_valid),
        .is_packet (is_packet),
        .wb_ready  (wb_ready),
        .fu_ready  (fu_ready),
        .ex_valid  (ex_valid),
        .ex_packet (ex_packet)
    );

    result_writeback wb_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .ex_valid    (ex_valid),
        .ex_packet   (ex_packet),
        .wb_ready    (wb_ready),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .res_rob_tag (res_rob_tag),
        .res_value   (res_value),
        .res_npc     (res_npc),
        .cdb_valid   (cdb_valid),
        .cdb_packet  (cdb_packet)
    );

endmodule

//--- tb_issue_core_assert.sv
// Issue slice handshake assertions

`timescale 1ns/1ns
`include "issue_defines.svh"

module tb_issue_core_assert (
    input logic              clock,
    input logic              arst_n,
    input logic              disp_ready,
    input logic              res_valid,
    input logic              res_ready,
    input logic [`TAG_W-1:0] res_rob_tag,
    input logic [`XLEN-1:0]  res_value,
    input logic [`XLEN-1:0]  res_npc
);

    int fail_count = 0;     // Summed into the closing count

    // Stalled result holds valid and payload
    property hold_while_stalled;
        @(posedge clock) disable iff (!arst_n)
            res_valid && !res_ready |=>
                res_valid && $stable(res_rob_tag) && $stable(res_value) && $stable(res_npc);
    endproperty

    // Empty station right after reset
    property ready_out_of_reset;
        @(posedge clock) $rose(arst_n) |-> disp_ready;
    endproperty

    hold_a: assert property (hold_while_stalled) else begin
        fail_count++;
        $error("result port changed while res_ready was low");
    end

    reset_a: assert property (ready_out_of_reset) else begin
        fail_count++;
        $error("disp_ready low right after reset");
    end

endmodule

//--- tb_issue_core.sv
// Issue slice testbench

`timescale 1ns/1ns
`include "issue_defines.svh"

module tb_issue_core;

    localparam int TIMEOUT_CYCLES = 2000;   // About 400 cycles of tests plus a wide margin
    localparam int NTAGS          = 2**`TAG_W;

    logic                 clock;
    logic                 arst_n;
    logic                 disp_valid;
    logic                 disp_ready;
    logic [`TAG_W-1:0]    disp_rob_tag;
    issue_pkg::alu_func_e disp_alu_func;
    logic                 disp_opa_valid;
    logic [`XLEN-1:0]     disp_opa;
    logic [`TAG_W-1:0]    disp_opa_tag;
    logic                 disp_opb_valid;
    logic [`XLEN-1:0]     disp_opb;
    logic [`TAG_W-1:0]    disp_opb_tag;
    logic [`XLEN-1:0]     disp_npc;
    logic                 res_valid;
    logic                 res_ready;
    logic [`TAG_W-1:0]    res_rob_tag;
    logic [`XLEN-1:0]     res_value;
    logic [`XLEN-1:0]     res_npc;

    // Scoreboard by tag
    issue_pkg::alu_func_e exp_func  [NTAGS];
    logic [`XLEN-1:0]     exp_a     [NTAGS];
    logic [`XLEN-1:0]     exp_b     [NTAGS];
    logic [`XLEN-1:0]     exp_val   [NTAGS];
    logic [`XLEN-1:0]     exp_npc   [NTAGS];
    logic                 pending   [NTAGS];    // Dispatched, not yet seen
    logic                 delivered [NTAGS];
    logic [`TAG_W-1:0]    res_order [$];        // Tags as they leave the port

    logic [31:0] lfsr_state  = 32'h703b_21fa;
    logic        bp_on       = 1'b0;            // Random res_ready
    int          errors      = 0;
    int          checks      = 0;
    int          tests       = 0;
    int          cycle_count = 0;

    issue_core_top dut_i (.*);

    bind issue_core_top tb_issue_core_assert assert_i (.*);

    initial clock = 1'b0;
    always #4 clock = ~clock;   // 8 ns period

    //////////////////////////////////////////////////
    // Random source and reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // Taps 32 22 2 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};   // One step per bit
        end
        return r;
    endfunction

    function automatic logic [`XLEN-1:0] alu_model(input issue_pkg::alu_func_e f,
                                                   input logic [`XLEN-1:0] a, b);
        case (f)
            issue_pkg::ALU_ADD: return a + b;
            issue_pkg::ALU_SUB: return a - b;
            issue_pkg::ALU_AND: return a & b;
            issue_pkg::ALU_OR:  return a | b;
            issue_pkg::ALU_XOR: return a ^ b;
            issue_pkg::ALU_SLL: return a << b[4:0];
            issue_pkg::ALU_SRL: return a >> b[4:0];
            default:            return ($signed(a) < $signed(b)) ? `XLEN'(1) : '0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic report(input string msg);
        errors++;
        $display("error @%0t: %s", $time, msg);
    endtask

    task automatic check_tag(input logic [`TAG_W-1:0] got, exp, input string what);
        checks++;
        if (got !== exp)
            report($sformatf("%s: tag %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_value(input logic [`XLEN-1:0] got, exp, input string what);
        checks++;
        if (got !== exp)
            report($sformatf("%s: %h, expected %h", what, got, exp));
    endtask

    task automatic check_alu(input issue_pkg::alu_func_e f, input logic [`XLEN-1:0] a, b,
                             input logic [`XLEN-1:0] got, input logic [`TAG_W-1:0] tag);
        logic [`XLEN-1:0] exp;
        exp = alu_model(f, a, b);
        checks++;
        if (got !== exp)
            report($sformatf("tag %0d %s(%h, %h) gave %h, expected %h",
                             tag, f.name(), a, b, got, exp));
    endtask

    task automatic check_bit(input logic got, exp, input string what);
        checks++;
        if (got !== exp)
            report($sformatf("%s: %b, expected %b", what, got, exp));
    endtask

    //////////////////////////////////////////////////
    // Result monitor and timeout
    //////////////////////////////////////////////////

    // Flops still hold pre-edge values here
    always @(posedge clock) begin
        if (arst_n && res_valid && res_ready) begin
            if (pending[res_rob_tag] !== 1'b1) begin
                errors++;
                $display("result with tag %0d was never dispatched or came twice", res_rob_tag);
            end else begin
                check_alu(exp_func[res_rob_tag], exp_a[res_rob_tag], exp_b[res_rob_tag],
                          res_value, res_rob_tag);
                check_value(res_npc, exp_npc[res_rob_tag], "npc");
            end
            pending[res_rob_tag]   = 1'b0;
            delivered[res_rob_tag] = 1'b1;
            res_order.push_back(res_rob_tag);
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Drivers
    //////////////////////////////////////////////////

    task automatic next_cycle();
        logic [31:0] r;
        @(negedge clock);
        if (bp_on) begin
            r = rand_bits(2);
            res_ready = |r;     // Ready about 3 cycles in 4
        end
    endtask

    task automatic clear_scoreboard();
        for (int t = 0; t < NTAGS; t++) begin
            pending[t]   = 1'b0;
            delivered[t] = 1'b0;
        end
        res_order.delete();
    endtask

    // Starts and ends on a falling edge; src of -1 means operand given
    task automatic dispatch(input int tag, input issue_pkg::alu_func_e f,
                            input int src_a, src_b, input logic [`XLEN-1:0] a, b);
        logic taken;
        if (src_a >= 0)
            a = exp_val[src_a];     // Producer's result
        if (src_b >= 0)
            b = exp_val[src_b];
        exp_func[tag] = f;
        exp_a[tag]    = a;
        exp_b[tag]    = b;
        exp_val[tag]  = alu_model(f, a, b);
        exp_npc[tag]  = rand_bits(32);
        pending[tag]  = 1'b1;
        disp_valid    = 1'b1;
        disp_rob_tag  = `TAG_W'(tag);
        disp_alu_func = f;
        disp_npc      = exp_npc[tag];
        taken         = 1'b0;
        while (!taken) begin
            // Already delivered producer goes in as a plain value
            disp_opa_valid = (src_a < 0) ? 1'b1 : delivered[src_a];
            disp_opb_valid = (src_b < 0) ? 1'b1 : delivered[src_b];
            disp_opa       = disp_opa_valid ? a : ~a;
            disp_opb       = disp_opb_valid ? b : ~b;
            disp_opa_tag   = (src_a < 0) ? '0 : `TAG_W'(src_a);
            disp_opb_tag   = (src_b < 0) ? '0 : `TAG_W'(src_b);
            @(posedge clock);
            taken = disp_ready;
            next_cycle();
        end
        disp_valid = 1'b0;
    endtask

    task automatic wait_results(input int n);
        while (res_order.size() < n)
            next_cycle();
    endtask

    function automatic int pos_of(input int tag);
        foreach (res_order[i])
            if (res_order[i] == `TAG_W'(tag))
                return i;
        return -1;
    endfunction

    task automatic finish_test(input string name, input int e0);
        tests++;
        $display("test %-12s %s, %0d errors", name, (errors == e0) ? "ok" : "bad", errors - e0);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_bit(res_valid, 1'b0, "res_valid after reset");
        check_bit(disp_ready, 1'b1, "disp_ready after reset");
        finish_test("reset", e0);
    endtask

    task automatic test_arith();
        int e0;
        logic [`XLEN-1:0] a, b;
        e0 = errors;
        clear_scoreboard();
        for (int i = 0; i < 40; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            dispatch(i, issue_pkg::alu_func_e'(i % 8), -1, -1, a, b);   // Every opcode
        end
        wait_results(40);
        finish_test("arithmetic", e0);
    endtask

    task automatic test_priority();
        int e0;
        logic [`XLEN-1:0] a, b;
        issue_pkg::alu_func_e f;
        e0 = errors;
        clear_scoreboard();
        res_ready = 1'b0;
        // Two fill the pipe, four the station
        for (int i = 0; i < 6; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            f = issue_pkg::alu_func_e'(rand_bits(3));
            dispatch(i, f, -1, -1, a, b);
        end
        check_bit(disp_ready, 1'b0, "disp_ready with station full");
        res_ready = 1'b1;
        wait_results(6);
        for (int i = 0; i < 6; i++)
            check_tag(res_order[i], `TAG_W'(i), "delivery order");
        finish_test("priority", e0);
    endtask

    task automatic test_wakeup();
        int e0;
        logic [`XLEN-1:0] a, b;
        e0 = errors;
        clear_scoreboard();
        a = rand_bits(32);
        b = rand_bits(32);
        dispatch(0, issue_pkg::ALU_ADD, -1, -1, a, b);
        dispatch(1, issue_pkg::ALU_SUB, 0, -1, '0, b);     // Waits on tag 0
        dispatch(2, issue_pkg::ALU_XOR, -1, 1, a, '0);     // Waits on tag 1
        dispatch(3, issue_pkg::ALU_OR, -1, -1, a, b);
        wait_results(4);
        check_bit(pos_of(1) > pos_of(0), 1'b1, "tag 1 after its producer");
        check_bit(pos_of(2) > pos_of(1), 1'b1, "tag 2 after its producer");
        finish_test("wakeup", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int sa, sb;
        logic [`XLEN-1:0] a, b;
        issue_pkg::alu_func_e f;
        e0 = errors;
        clear_scoreboard();
        bp_on = 1'b1;
        for (int t = 0; t < 30; t++) begin
            a  = rand_bits(32);
            b  = rand_bits(32);
            f  = issue_pkg::alu_func_e'(rand_bits(3));
            sa = -1;
            sb = -1;
            // Producers among the last four
            if (t >= 4 && rand_bits(1) == 1)
                sa = t - 1 - int'(rand_bits(2));
            if (t >= 4 && rand_bits(2) == 0)
                sb = t - 1 - int'(rand_bits(2));
            dispatch(t, f, sa, sb, a, b);
        end
        wait_results(30);
        bp_on     = 1'b0;
        res_ready = 1'b1;
        for (int t = 0; t < 30; t++)
            check_bit(delivered[t], 1'b1, $sformatf("tag %0d delivered", t));
        finish_test("backpressure", e0);
    endtask

    initial begin
        int total;
        arst_n         = 1'b0;
        disp_valid     = 1'b0;
        disp_rob_tag   = '0;
        disp_alu_func  = issue_pkg::ALU_ADD;
        disp_opa_valid = 1'b0;
        disp_opa       = '0;
        disp_opa_tag   = '0;
        disp_opb_valid = 1'b0;
        disp_opb       = '0;
        disp_opb_tag   = '0;
        disp_npc       = '0;
        res_ready      = 1'b1;
        clear_scoreboard();
        repeat (10) @(negedge clock);
        arst_n = 1'b1;

        test_reset();
        test_arith();
        test_priority();
        test_wakeup();
        test_backpressure();

        total = errors + dut_i.assert_i.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, total);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
issue_pkg.sv
rs_if.sv
reservation_station.sv
stage_is.sv
alu_unit.sv
result_writeback.sv
issue_core_top.sv
tb_issue_core_assert.sv
tb_issue_core.sv

//--- Bender.yml
package:
  name: issue_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - issue_pkg.sv
      - rs_if.sv
      - reservation_station.sv
      - stage_is.sv
      - alu_unit.sv
      - result_writeback.sv
      - issue_core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_issue_core_assert.sv
      - tb_issue_core.sv
